// ==== serv_lite.f ====
serv_lite_pkg.sv
serv_lite_decode.sv
serv_lite_ctrl.sv
serv_lite_rf.sv
serv_lite_alu.sv
serv_lite_mem_if.sv
serv_lite_top.sv
serv_lite_tb.sv

// ==== serv_lite_alu.sv ====
module serv_lite_alu (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  serv_lite_pkg::ctrl_sig_t i_ctrl,
   input  logic                     i_rs1_bit,
   input  logic                     i_rs2_bit,
   output logic                     o_sum_bit,
   output logic                     o_eq
);

   logic sub;
   logic op_b;
   logic b_inv;
   logic cin;
   logic carry_q;
   logic eq_q;
   logic compare;
   logic match;

   assign sub   = (i_ctrl.alu_op == serv_lite_pkg::SUB);
   assign op_b  = i_ctrl.op_b_imm ? i_ctrl.imm : i_rs2_bit;
   assign b_inv = op_b ^ sub;
   // Subtract is rs1 + ~b + 1, the one comes in as the first carry.
   assign cin   = i_ctrl.alu_init ? sub : carry_q;

   assign o_sum_bit = i_rs1_bit ^ b_inv ^ cin;
   assign match     = ~(i_rs1_bit ^ op_b);
   assign compare   = i_ctrl.cnt_en & ~i_ctrl.run & ~i_ctrl.mem_init;
   assign o_eq      = eq_q;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry_q <= 1'b0;
         eq_q    <= 1'b0;
      end else begin
         if (i_ctrl.cnt_en) begin
            carry_q <= (i_rs1_bit & b_inv) | (cin & (i_rs1_bit ^ b_inv));
         end
         if (compare) begin
            eq_q <= match & (i_ctrl.alu_init | eq_q);
         end
      end
   end

endmodule

// ==== serv_lite_ctrl.sv ====
module serv_lite_ctrl (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  serv_lite_pkg::ctrl_sig_t i_ctrl,
   input  logic                     i_fetch,
   output serv_lite_pkg::wb_req_t   o_ibus,
   input  logic                     i_ibus_ack,
   output logic                     o_rd_bit
);

   logic [serv_lite_pkg::XLEN-1:0] pc;
   logic                           cyc;
   logic [1:0]                     four;
   logic                           add4;
   logic                           c4_q;
   logic                           ci_q;
   logic                           c4_in;
   logic                           ci_in;
   logic                           sum4;
   logic                           sumi;

   // Marker for the single set bit of the constant 4.
   assign add4  = ~i_ctrl.alu_init & four[0];
   assign c4_in = ~i_ctrl.alu_init & c4_q;
   assign ci_in = ~i_ctrl.alu_init & ci_q;
   assign sum4  = pc[0] ^ add4 ^ c4_in;
   assign sumi  = pc[0] ^ i_ctrl.imm ^ ci_in;

   assign o_rd_bit = i_ctrl.auipc ? sumi : sum4;

   assign o_ibus.adr = pc;
   assign o_ibus.dat = '0;
   assign o_ibus.we  = 1'b0;
   assign o_ibus.cyc = cyc;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc   <= serv_lite_pkg::RESET_PC;
         cyc  <= 1'b0;
         four <= '0;
         c4_q <= 1'b0;
         ci_q <= 1'b0;
      end else begin
         if (cyc) cyc <= ~i_ibus_ack;
         else     cyc <= i_fetch;
         four <= i_ctrl.alu_init ? 2'b10 : {1'b0, four[1]};
         c4_q <= (pc[0] & add4) | (c4_in & (pc[0] ^ add4));
         ci_q <= (pc[0] & i_ctrl.imm) | (ci_in & (pc[0] ^ i_ctrl.imm));
         // New PC enters at the top as the old one leaves at the bottom.
         if (i_ctrl.run) begin
            pc <= {(i_ctrl.jump ? sumi : sum4), pc[serv_lite_pkg::XLEN-1:1]};
         end
      end
   end

endmodule

// ==== serv_lite_decode.sv ====
module serv_lite_decode (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  logic [31:0]              i_ibus_rdt,
   input  logic                     i_ibus_ack,
   input  logic                     i_alu_eq,
   input  logic                     i_mem_busy,
   output logic                     o_fetch,
   output serv_lite_pkg::ctrl_sig_t o_ctrl,
   output logic [4:0]               o_cnt,
   output logic [4:0]               o_rs1_addr,
   output logic [4:0]               o_rs2_addr,
   output logic [4:0]               o_rd_addr
);

   serv_lite_pkg::state_e  state;
   serv_lite_pkg::opcode_e opcode;
   serv_lite_pkg::opcode_e fetch_op;
   logic [31:0]            ir;
   logic [4:0]             cnt;
   logic                   go;
   logic                   run;
   logic                   cnt_en;
   logic                   cnt_done;
   logic                   mem_op;
   logic                   writes_rd;
   logic                   imm;

   assign opcode   = serv_lite_pkg::opcode_e'(ir[6:2]);
   assign fetch_op = serv_lite_pkg::opcode_e'(i_ibus_rdt[6:2]);
   assign mem_op   = (opcode == serv_lite_pkg::LOAD) | (opcode == serv_lite_pkg::STORE);

   assign writes_rd = (opcode == serv_lite_pkg::LUI)   | (opcode == serv_lite_pkg::AUIPC) |
                      (opcode == serv_lite_pkg::JAL)   | (opcode == serv_lite_pkg::OPIMM) |
                      (opcode == serv_lite_pkg::OP)    | (opcode == serv_lite_pkg::LOAD);

   assign o_fetch  = (state == serv_lite_pkg::IDLE);
   assign go       = o_fetch & i_ibus_ack;
   assign run      = (state == serv_lite_pkg::RUN);
   assign cnt_en   = run | (state == serv_lite_pkg::COMPARE) | (state == serv_lite_pkg::MEM_INIT);
   assign cnt_done = (cnt == 5'd31);

   assign o_cnt      = cnt;
   assign o_rd_addr  = ir[11:7];
   assign o_rs1_addr = ir[19:15];
   assign o_rs2_addr = ir[24:20];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= serv_lite_pkg::IDLE;
         cnt   <= '0;
         ir    <= '0;
      end else begin
         if (go) begin
            ir <= i_ibus_rdt;
         end
         if (cnt_en) begin
            cnt <= cnt + 5'd1;
         end
         case (state)
            serv_lite_pkg::IDLE: begin
               if (go) begin
                  if (fetch_op == serv_lite_pkg::BRANCH) begin
                     state <= serv_lite_pkg::COMPARE;
                  end else if ((fetch_op == serv_lite_pkg::LOAD) ||
                               (fetch_op == serv_lite_pkg::STORE)) begin
                     state <= serv_lite_pkg::MEM_INIT;
                  end else begin
                     state <= serv_lite_pkg::RUN;
                  end
               end
            end
            serv_lite_pkg::COMPARE:  if (cnt_done) state <= serv_lite_pkg::RUN;
            serv_lite_pkg::MEM_INIT: if (cnt_done) state <= serv_lite_pkg::MEM_WAIT;
            serv_lite_pkg::MEM_WAIT: if (!i_mem_busy) state <= serv_lite_pkg::RUN;
            serv_lite_pkg::RUN:      if (cnt_done) state <= serv_lite_pkg::IDLE;
            default:                 state <= serv_lite_pkg::IDLE;
         endcase
      end
   end

   // Immediate bit cnt, LSB first, per format.
   always_comb begin
      imm = 1'b0;
      case (opcode)
         serv_lite_pkg::OPIMM, serv_lite_pkg::LOAD: begin
            if (cnt > 5'd10) imm = ir[31];
            else             imm = ir[cnt + 5'd20];
         end
         serv_lite_pkg::STORE: begin
            if (cnt > 5'd10)     imm = ir[31];
            else if (cnt > 5'd4) imm = ir[cnt + 5'd20];
            else                 imm = ir[cnt + 5'd7];
         end
         serv_lite_pkg::BRANCH: begin
            if (cnt > 5'd11)      imm = ir[31];
            else if (cnt > 5'd10) imm = ir[7];
            else if (cnt > 5'd4)  imm = ir[cnt + 5'd20];
            else if (cnt > 5'd0)  imm = ir[cnt + 5'd7];
         end
         serv_lite_pkg::LUI, serv_lite_pkg::AUIPC: begin
            if (cnt > 5'd11) imm = ir[cnt];
         end
         serv_lite_pkg::JAL: begin
            if (cnt > 5'd19)      imm = ir[31];
            else if (cnt > 5'd11) imm = ir[cnt];
            else if (cnt > 5'd10) imm = ir[20];
            else if (cnt > 5'd0)  imm = ir[cnt + 5'd20];
         end
         default: imm = 1'b0;
      endcase
   end

   always_comb begin
      o_ctrl          = '0;
      o_ctrl.cnt_en   = cnt_en;
      o_ctrl.run      = run;
      o_ctrl.rd_en    = run & writes_rd;
      // BEQ takes the branch on equal, BNE on not equal.
      o_ctrl.jump     = run & ((opcode == serv_lite_pkg::JAL) |
                               ((opcode == serv_lite_pkg::BRANCH) & (i_alu_eq ^ ir[12])));
      o_ctrl.auipc    = (opcode == serv_lite_pkg::AUIPC);
      o_ctrl.alu_op   = ((opcode == serv_lite_pkg::OP) && ir[30]) ? serv_lite_pkg::SUB
                                                                   : serv_lite_pkg::ADD;
      o_ctrl.alu_init = cnt_en & (cnt == 5'd0);
      o_ctrl.op_b_imm = cnt_en & ((opcode == serv_lite_pkg::OPIMM) | mem_op);
      o_ctrl.mem_init = (state == serv_lite_pkg::MEM_INIT);
      o_ctrl.mem_we   = (opcode == serv_lite_pkg::STORE);
      o_ctrl.mem_go   = (state == serv_lite_pkg::MEM_INIT) & cnt_done;
      o_ctrl.imm      = imm;
      if (run) begin
         case (opcode)
            serv_lite_pkg::OPIMM, serv_lite_pkg::OP: o_ctrl.rd_source = serv_lite_pkg::ALU;
            serv_lite_pkg::LUI:                      o_ctrl.rd_source = serv_lite_pkg::IMM;
            serv_lite_pkg::LOAD:                     o_ctrl.rd_source = serv_lite_pkg::MEM;
            default:                                 o_ctrl.rd_source = serv_lite_pkg::CTRL;
         endcase
      end
   end

endmodule

// ==== serv_lite_mem_if.sv ====
module serv_lite_mem_if (
   input  logic                     clk,
   input  logic                     i_arst_n,
   input  serv_lite_pkg::ctrl_sig_t i_ctrl,
   input  logic                     i_addr_bit,
   input  logic                     i_dat_bit,
   output serv_lite_pkg::wb_req_t   o_dbus,
   input  logic [31:0]              i_dbus_rdt,
   input  logic                     i_dbus_ack,
   output logic                     o_mem_busy,
   output logic                     o_rd_bit
);

   logic [31:0] adr_q;
   logic [31:0] dat_q;
   logic        cyc_q;

   assign o_dbus.adr = adr_q;
   assign o_dbus.dat = dat_q;
   assign o_dbus.we  = i_ctrl.mem_we;
   assign o_dbus.cyc = cyc_q;

   assign o_mem_busy = cyc_q & ~i_dbus_ack;
   assign o_rd_bit   = dat_q[0];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cyc_q <= 1'b0;
      end else if (i_ctrl.mem_go) begin
         cyc_q <= 1'b1;
      end else if (i_dbus_ack) begin
         cyc_q <= 1'b0;
      end
   end

   // Store data and load data share one shift register.
   always_ff @(posedge clk) begin
      if (i_ctrl.mem_init) begin
         adr_q <= {i_addr_bit, adr_q[31:1]};
         dat_q <= {i_dat_bit, dat_q[31:1]};
      end else if (cyc_q && i_dbus_ack && !i_ctrl.mem_we) begin
         dat_q <= i_dbus_rdt;
      end else if (i_ctrl.run) begin
         dat_q <= {1'b0, dat_q[31:1]};
      end
   end

endmodule

// ==== serv_lite_pkg.sv ====
package serv_lite_pkg;

   localparam int unsigned XLEN = 32;
   localparam logic [XLEN-1:0] RESET_PC = '0;

   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      MEM_INIT,
      MEM_WAIT,
      RUN
   } state_e;

   // Major opcodes, instruction bits 6 to 2.
   typedef enum logic [4:0] {
      LOAD   = 5'b00000,
      STORE  = 5'b01000,
      OPIMM  = 5'b00100,
      AUIPC  = 5'b00101,
      OP     = 5'b01100,
      LUI    = 5'b01101,
      BRANCH = 5'b11000,
      JAL    = 5'b11011
   } opcode_e;

   typedef enum logic [1:0] {CTRL, ALU, IMM, MEM} rd_source_e;

   typedef enum logic {ADD, SUB} alu_op_e;

   // Wishbone classic master request, stb follows cyc.
   typedef struct packed {
      logic [XLEN-1:0] adr;
      logic [XLEN-1:0] dat;
      logic            we;
      logic            cyc;
   } wb_req_t;

   typedef struct packed {
      logic       cnt_en;
      logic       run;
      logic       rd_en;
      logic       jump;
      logic       auipc;
      alu_op_e    alu_op;
      logic       alu_init;
      logic       op_b_imm;
      logic       mem_init;
      logic       mem_we;
      logic       mem_go;
      logic       imm;
      rd_source_e rd_source;
   } ctrl_sig_t;

endpackage

// ==== serv_lite_rf.sv ====
module serv_lite_rf (
   input  logic       clk,
   input  logic       i_arst_n,
   input  logic [4:0] i_cnt,
   input  logic [4:0] i_rs1_addr,
   input  logic [4:0] i_rs2_addr,
   input  logic [4:0] i_rd_addr,
   input  logic       i_rd_en,
   input  logic       i_rd_bit,
   output logic       o_rs1_bit,
   output logic       o_rs2_bit
);

   logic [serv_lite_pkg::XLEN-1:0] regs [32];
   logic                           wr_en;

   // x0 is never written and keeps its reset value.
   assign wr_en = i_rd_en & (i_rd_addr != 5'd0);

   // Both ports read the same bit position that is being written.
   assign o_rs1_bit = regs[i_rs1_addr][i_cnt];
   assign o_rs2_bit = regs[i_rs2_addr][i_cnt];

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[i_rd_addr][i_cnt] <= i_rd_bit;
      end
   end

endmodule

// ==== serv_lite_tb.sv ====
module serv_lite_tb;

   localparam int NUM_INSTR = 400;
   localparam int WATCHDOG_TIME = NUM_INSTR * (64 + 2 * 4) * 10 + 5000;

   logic                   clk;
   logic                   arst_n;
   serv_lite_pkg::wb_req_t ibus;
   logic [31:0]            ibus_rdt;
   logic                   ibus_ack;
   serv_lite_pkg::wb_req_t dbus;
   logic [31:0]            dbus_rdt;
   logic                   dbus_ack;

   logic [31:0]            xreg [32];
   logic [31:0]            pc;
   logic [31:0]            imem [logic [31:0]];
   logic [31:0]            ref_mem [logic [31:0]];
   logic [31:0]            dmem [logic [31:0]];
   serv_lite_pkg::wb_req_t exp_q [$];
   serv_lite_pkg::wb_req_t exp_req;
   serv_lite_pkg::wb_req_t ibus_prev;
   serv_lite_pkg::wb_req_t dbus_prev;
   int                     ibus_wait;
   int                     dbus_wait;
   int                     fetches;
   logic                   done;

   serv_lite_top uut (
      .clk        (clk),
      .i_arst_n   (arst_n),
      .o_ibus     (ibus),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus     (dbus),
      .i_dbus_rdt (dbus_rdt),
      .i_dbus_ack (dbus_ack)
   );

   always #5 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on the first error.");
   endtask

   // Contents of a data word that was never written.
   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return {addr[15:0], addr[31:16]} ^ 32'h5a3c_c3a5;
   endfunction

   function automatic logic [6:0] opcode_bits(input serv_lite_pkg::opcode_e op);
      return {op, 2'b11};
   endfunction

   function automatic logic [31:0] gen_instr();
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [31:0] rnd;
      logic [31:0] jmp;
      logic [31:0] tgt;
      logic [31:0] mof;
      int          kind;
      rd   = 5'($urandom_range(7, 0));
      rs1  = 5'($urandom_range(7, 0));
      rs2  = 5'($urandom_range(7, 0));
      rnd  = $urandom;
      jmp  = 32'($urandom_range(8, 1)) << 2;
      tgt  = 32'h400 + (32'($urandom_range(15, 0)) << 2);
      mof  = '0;
      kind = $urandom_range(9, 0);
      if (kind >= 8) begin
         mof = tgt - xreg[rs1];
         // Base register too far from the target so the access uses x0.
         if ($signed(mof) > 2047 || $signed(mof) < -2048) begin
            rs1 = 5'd0;
            mof = tgt;
         end
      end
      case (kind)
         0: return {rnd[31:12], rd, opcode_bits(serv_lite_pkg::LUI)};
         1: return {rnd[31:12], rd, opcode_bits(serv_lite_pkg::AUIPC)};
         2: return {1'b0, jmp[10:1], jmp[11], jmp[19:12], rd, opcode_bits(serv_lite_pkg::JAL)};
         3: return {rnd[11:0], rs1, 3'b000, rd, opcode_bits(serv_lite_pkg::OPIMM)};
         4: return {7'b0000000, rs2, rs1, 3'b000, rd, opcode_bits(serv_lite_pkg::OP)};
         5: return {7'b0100000, rs2, rs1, 3'b000, rd, opcode_bits(serv_lite_pkg::OP)};
         6: return {1'b0, jmp[10:5], rs2, rs1, 3'b000, jmp[4:1], jmp[11],
                    opcode_bits(serv_lite_pkg::BRANCH)};
         7: return {1'b0, jmp[10:5], rs2, rs1, 3'b001, jmp[4:1], jmp[11],
                    opcode_bits(serv_lite_pkg::BRANCH)};
         8: return {mof[11:0], rs1, 3'b010, rd, opcode_bits(serv_lite_pkg::LOAD)};
         default: return {mof[11:5], rs2, rs1, 3'b010, mof[4:0],
                          opcode_bits(serv_lite_pkg::STORE)};
      endcase
   endfunction

   task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
      if (rd != 5'd0) begin
         xreg[rd] = val;
      end
   endtask

   // Instruction-set model that runs one instruction per accepted fetch.
   task automatic execute(input logic [31:0] ins);
      logic [31:0]            r1;
      logic [31:0]            r2;
      logic [31:0]            imm_i;
      logic [31:0]            imm_s;
      logic [31:0]            imm_b;
      logic [31:0]            imm_j;
      logic [31:0]            imm_u;
      logic [31:0]            next_pc;
      logic [31:0]            addr;
      serv_lite_pkg::wb_req_t req;
      r1      = xreg[ins[19:15]];
      r2      = xreg[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      imm_u   = {ins[31:12], 12'd0};
      next_pc = pc + 32'd4;
      req     = '0;
      case (serv_lite_pkg::opcode_e'(ins[6:2]))
         serv_lite_pkg::LUI:   write_reg(ins[11:7], imm_u);
         serv_lite_pkg::AUIPC: write_reg(ins[11:7], pc + imm_u);
         serv_lite_pkg::OPIMM: write_reg(ins[11:7], r1 + imm_i);
         serv_lite_pkg::OP:    write_reg(ins[11:7], ins[30] ? r1 - r2 : r1 + r2);
         serv_lite_pkg::JAL: begin
            write_reg(ins[11:7], pc + 32'd4);
            next_pc = pc + imm_j;
         end
         serv_lite_pkg::BRANCH: begin
            if ((r1 == r2) != ins[12]) next_pc = pc + imm_b;
         end
         serv_lite_pkg::LOAD: begin
            addr = r1 + imm_i;
            write_reg(ins[11:7], ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr));
            req.adr = addr;
            req.cyc = 1'b1;
            exp_q.push_back(req);
         end
         serv_lite_pkg::STORE: begin
            addr = r1 + imm_s;
            ref_mem[addr] = r2;
            req = '{adr: addr, dat: r2, we: 1'b1, cyc: 1'b1};
            exp_q.push_back(req);
         end
         default: ;
      endcase
      pc = next_pc;
   endtask

   // Request must hold until ack, and cyc falls right after it.
   task automatic check_wb(input string bus, input serv_lite_pkg::wb_req_t now,
                           input serv_lite_pkg::wb_req_t prev, input logic ack);
      if (ack) begin
         assert (!now.cyc) else
            abort_run($sformatf("FAILED at time %0t: %s cyc still high after ack", $time, bus));
      end else if (prev.cyc) begin
         assert (now == prev) else
            abort_run($sformatf("FAILED at time %0t: %s request changed before ack",
                                $time, bus));
      end
   endtask

   always @(negedge clk) begin
      if (!arst_n) begin
         assert (!ibus.cyc && !dbus.cyc) else abort_run("A bus cycle was started during reset.");
      end else begin
         check_wb("instruction bus", ibus, ibus_prev, ibus_ack);
         if (ibus_ack) begin
            ibus_ack = 1'b0;
         end else if (ibus.cyc) begin
            if (!ibus_prev.cyc) begin
               assert (ibus.adr == pc && !ibus.we) else
                  abort_run($sformatf("FAILED at time %0t: fetch from %h we %b, model PC is %h",
                                      $time, ibus.adr, ibus.we, pc));
               ibus_wait = $urandom_range(3, 0);
               if (fetches == NUM_INSTR) done = 1'b1;
            end
            if (ibus_wait == 0 && !done) begin
               if (!imem.exists(ibus.adr)) imem[ibus.adr] = gen_instr();
               ibus_rdt = imem[ibus.adr];
               ibus_ack = 1'b1;
               execute(ibus_rdt);
               fetches++;
            end else if (ibus_wait > 0) begin
               ibus_wait--;
            end
         end
         ibus_prev = ibus;
      end
   end

   always @(negedge clk) begin
      if (arst_n) begin
         check_wb("data bus", dbus, dbus_prev, dbus_ack);
         if (dbus_ack) begin
            dbus_ack = 1'b0;
         end else if (dbus.cyc) begin
            if (!dbus_prev.cyc) begin
               assert (exp_q.size() > 0) else
                  abort_run("The core started a data-bus cycle that the model did not expect.");
               exp_req = exp_q.pop_front();
               assert (dbus.adr == exp_req.adr && dbus.we == exp_req.we &&
                       (!exp_req.we || dbus.dat == exp_req.dat)) else
                  abort_run($sformatf({"FAILED at time %0t: data bus adr %h we %b dat %h, ",
                                       "expected adr %h we %b dat %h"}, $time, dbus.adr,
                                      dbus.we, dbus.dat, exp_req.adr, exp_req.we,
                                      exp_req.dat));
               dbus_wait = $urandom_range(3, 0);
            end
            if (dbus_wait == 0) begin
               if (dbus.we) dmem[dbus.adr] = dbus.dat;
               else dbus_rdt = dmem.exists(dbus.adr) ? dmem[dbus.adr] : fill_word(dbus.adr);
               dbus_ack = 1'b1;
            end else begin
               dbus_wait--;
            end
         end
         dbus_prev = dbus;
      end
   end

   initial begin
      #(WATCHDOG_TIME);
      abort_run("Timeout: the core stopped fetching instructions.");
   end

   initial begin
      void'($urandom(34637));
      clk       = 1'b0;
      arst_n    = 1'b0;
      ibus_rdt  = '0;
      ibus_ack  = 1'b0;
      dbus_rdt  = '0;
      dbus_ack  = 1'b0;
      ibus_prev = '0;
      dbus_prev = '0;
      ibus_wait = 0;
      dbus_wait = 0;
      fetches   = 0;
      done      = 1'b0;
      pc        = serv_lite_pkg::RESET_PC;
      foreach (xreg[i]) begin
         xreg[i] = '0;
      end
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      wait (done);
      if (exp_q.size() == 0) begin
         $display("Result: PASSED");
         $finish;
      end else begin
         abort_run("The model expected data-bus accesses that never appeared.");
      end
   end

endmodule

// ==== serv_lite_top.sv ====
module serv_lite_top (
   input  logic                   clk,
   input  logic                   i_arst_n,
   output serv_lite_pkg::wb_req_t o_ibus,
   input  logic [31:0]            i_ibus_rdt,
   input  logic                   i_ibus_ack,
   output serv_lite_pkg::wb_req_t o_dbus,
   input  logic [31:0]            i_dbus_rdt,
   input  logic                   i_dbus_ack
);

   serv_lite_pkg::ctrl_sig_t ctrl;
   logic                     fetch;
   logic                     alu_eq;
   logic                     mem_busy;
   logic [4:0]               cnt;
   logic [4:0]               rs1_addr;
   logic [4:0]               rs2_addr;
   logic [4:0]               rd_addr;
   logic                     rs1_bit;
   logic                     rs2_bit;
   logic                     sum_bit;
   logic                     ctrl_rd_bit;
   logic                     mem_rd_bit;
   logic                     rd_bit;

   // Destination bit stream.
   assign rd_bit = (ctrl.rd_source == serv_lite_pkg::ALU) ? sum_bit     :
                   (ctrl.rd_source == serv_lite_pkg::IMM) ? ctrl.imm    :
                   (ctrl.rd_source == serv_lite_pkg::MEM) ? mem_rd_bit  :
                                                            ctrl_rd_bit;

   serv_lite_decode u_decode (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_alu_eq   (alu_eq),
      .i_mem_busy (mem_busy),
      .o_fetch    (fetch),
      .o_ctrl     (ctrl),
      .o_cnt      (cnt),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr)
   );

   serv_lite_ctrl u_ctrl (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ctrl     (ctrl),
      .i_fetch    (fetch),
      .o_ibus     (o_ibus),
      .i_ibus_ack (i_ibus_ack),
      .o_rd_bit   (ctrl_rd_bit)
   );

   serv_lite_rf u_rf (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_en    (ctrl.rd_en),
      .i_rd_bit   (rd_bit),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit)
   );

   serv_lite_alu u_alu (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ctrl     (ctrl),
      .i_rs1_bit  (rs1_bit),
      .i_rs2_bit  (rs2_bit),
      .o_sum_bit  (sum_bit),
      .o_eq       (alu_eq)
   );

   serv_lite_mem_if u_mem_if (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ctrl     (ctrl),
      .i_addr_bit (sum_bit),
      .i_dat_bit  (rs2_bit),
      .o_dbus     (o_dbus),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (i_dbus_ack),
      .o_mem_busy (mem_busy),
      .o_rd_bit   (mem_rd_bit)
   );

endmodule
